/* source/host_pkg.sv */
`default_nettype none

package host_pkg;

    ////////////////////////////////////////
    // host wires and triggers
    ////////////////////////////////////////

    // one wire-in or pipe word from the host
    typedef logic [15:0] host_word_t;

    // trigger-in vector with one strobe per bit
    typedef logic [15:0] trig_vec_t;

    // trigger bit that loads the timing rate
    localparam int TRIG_RATE = 7;

    // half period of the simulation tick in ep50trig cycles
    typedef logic [17:0] half_cnt_t;

    // rate after power-up until the host writes one
    localparam half_cnt_t DEFAULT_HALF_CNT = 18'd500;

    ////////////////////////////////////////
    // waveform buffer
    ////////////////////////////////////////

    // capacity in 32-bit elements
    localparam int WAVE_DEPTH = 256;

    typedef logic [$clog2(WAVE_DEPTH)-1:0] wave_addr_t;

    // one bit wider than the address so a full buffer can be counted
    typedef logic [$clog2(WAVE_DEPTH):0] wave_cnt_t;

endpackage

`default_nettype wire

/* source/spi_pkg.sv */
`default_nettype none

package spi_pkg;

    ////////////////////////////////////////
    // frame and bit timing
    ////////////////////////////////////////

    // one IEEE single per frame
    typedef logic [31:0] frame_t;

    localparam int FRAME_BITS = 32;

    // ep50trig cycles per sck half period
    localparam int SPI_CLK_DIV = 13;

    typedef logic [4:0] div_cnt_t;

    // wide enough to hold FRAME_BITS itself
    typedef logic [5:0] bit_cnt_t;

endpackage

`default_nettype wire

/* source/sim_clock_gen.sv */
`default_nettype none

module sim_clock_gen
    import host_pkg::*;
(
    input  wire logic       ep50trig,
    input  wire logic       reset_global,
    input  wire trig_vec_t  trig,
    input  wire host_word_t rate_word,
    output logic            sim_tick,
    output logic            spindle_tick
);

    ////////////////////////////////////////
    // rate register
    ////////////////////////////////////////

    half_cnt_t half_cnt;

    // one bit more than the half count to cover the full period
    logic [$bits(half_cnt_t):0] period_cnt;
    logic [$bits(half_cnt_t):0] period_last;
    logic                       rate_load;

    // only the rate bit of the trigger vector matters here
    assign rate_load = trig[TRIG_RATE];

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            half_cnt <= DEFAULT_HALF_CNT;
        else if (rate_load)
            // zero-extend the 16-bit wire value
            half_cnt <= half_cnt_t'(rate_word);
    end

    ////////////////////////////////////////
    // period counter
    ////////////////////////////////////////

    // last count of the period is 2*half+1
    assign period_last = {half_cnt, 1'b1};

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
            period_cnt <= '0;
        // a new rate restarts the period from zero
        else if (rate_load)
            period_cnt <= '0;
        else if (sim_tick)
            period_cnt <= '0;
        else
            period_cnt <= period_cnt + 1'b1;
    end

    // sim tick at the end of the period
    assign sim_tick = (period_cnt == period_last);

    // capture tick halfway through
    assign spindle_tick = (period_cnt == {1'b0, half_cnt});

    // a count past the period end would lose every later tick
    a_cnt_in_period: assert property (@(posedge ep50trig) disable iff (reset_global)
        period_cnt <= period_last);

endmodule

`default_nettype wire

/* source/length_waveform.sv */
`default_nettype none

module length_waveform
    import host_pkg::*;
    import spi_pkg::*;
(
    input  wire logic       ep50trig,
    input  wire logic       reset_global,
    input  wire logic       reset_sim,
    input  wire logic       pipe_write,
    input  wire host_word_t pipe_data,
    input  wire logic       sim_tick,
    output frame_t          muscle_len,
    output logic            lce_valid
);

    // low half waiting for its high half
    logic       have_low;
    host_word_t low_half;

    // element store
    frame_t     wave_mem [WAVE_DEPTH];
    wave_cnt_t  stored_cnt;
    wave_addr_t wr_addr;
    wave_addr_t rd_addr;

    logic       pair_done;
    logic       room_left;
    logic       replay_step;
    logic       rd_last;

    ////////////////////////////////////////
    // pipe feed
    ////////////////////////////////////////

    // second word of a pair completes an element
    assign pair_done = pipe_write && have_low;

    // extra pairs past a full buffer get dropped
    assign room_left = (stored_cnt < wave_cnt_t'(WAVE_DEPTH));

    always_ff @(posedge ep50trig)
    begin
        if (pipe_write && !have_low)
            low_half <= pipe_data;
        // high half arrives second
        if (pair_done && room_left && !reset_sim)
            wave_mem[wr_addr] <= {pipe_data, low_half};
    end

    ////////////////////////////////////////
    // replay
    ////////////////////////////////////////

    assign replay_step = sim_tick && (stored_cnt != '0);

    // wrap after the last stored element, not at the depth
    assign rd_last = ((wave_cnt_t'(rd_addr) + 1'b1) == stored_cnt);

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            have_low   <= 1'b0;
            stored_cnt <= '0;
            wr_addr    <= '0;
            rd_addr    <= '0;
            lce_valid  <= 1'b0;
            muscle_len <= '0;
        end
        // host asked to refill the buffer
        else if (reset_sim)
        begin
            have_low   <= 1'b0;
            stored_cnt <= '0;
            wr_addr    <= '0;
            rd_addr    <= '0;
            lce_valid  <= 1'b0;
            muscle_len <= '0;
        end
        else
        begin
            // pair phase flips on every pipe word
            if (pipe_write)
                have_low <= !have_low;
            if (pair_done && room_left)
            begin
                stored_cnt <= stored_cnt + 1'b1;
                wr_addr    <= wr_addr + 1'b1;
            end
            // empty buffer keeps the last length
            if (replay_step)
            begin
                muscle_len <= wave_mem[rd_addr];
                lce_valid  <= 1'b1;
                if (rd_last)
                    rd_addr <= '0;
                else
                    rd_addr <= rd_addr + 1'b1;
            end
        end
    end

    // replay never reads past what has been fed
    a_rd_in_range: assert property (@(posedge ep50trig) disable iff (reset_global)
        (stored_cnt != '0) |-> (wave_cnt_t'(rd_addr) < stored_cnt));

endmodule

`default_nettype wire

/* source/spi_frame_tx.sv */
`default_nettype none

module spi_frame_tx
    import spi_pkg::*;
(
    input  wire logic   ep50trig,
    input  wire logic   reset_global,
    input  wire logic   sim_tick,
    input  wire frame_t muscle_len,
    output logic        sck,
    output logic        mosi,
    output logic        ssel
);

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_SHIFT,
        TX_GAP
    } tx_state_t;

    tx_state_t state;
    frame_t    shift_reg;
    div_cnt_t  div_cnt;
    bit_cnt_t  bit_cnt;
    logic      div_done;

    // end of one sck half period
    assign div_done = (div_cnt == div_cnt_t'(SPI_CLK_DIV - 1));

    ////////////////////////////////////////
    // frame FSM
    ////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            state   <= TX_IDLE;
            sck     <= 1'b0;
            mosi    <= 1'b0;
            ssel    <= 1'b1;
            div_cnt <= '0;
            bit_cnt <= '0;
        end
        else
        begin
            case (state)
                TX_IDLE:
                begin
                    // ticks only start a frame from idle
                    if (sim_tick)
                    begin
                        state   <= TX_SHIFT;
                        ssel    <= 1'b0;
                        mosi    <= muscle_len[FRAME_BITS-1];
                        div_cnt <= '0;
                        bit_cnt <= '0;
                    end
                end
                TX_SHIFT:
                begin
                    if (div_done)
                    begin
                        div_cnt <= '0;
                        sck     <= !sck;
                        // falling edge moves to the next bit
                        if (sck)
                        begin
                            if (bit_cnt == bit_cnt_t'(FRAME_BITS - 1))
                            begin
                                state <= TX_GAP;
                                mosi  <= 1'b0;
                            end
                            else
                            begin
                                bit_cnt <= bit_cnt + 1'b1;
                                mosi    <= shift_reg[FRAME_BITS-2];
                            end
                        end
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                end
                TX_GAP:
                begin
                    // one half period before ssel releases
                    if (div_done)
                    begin
                        state   <= TX_IDLE;
                        ssel    <= 1'b1;
                        div_cnt <= '0;
                    end
                    else
                        div_cnt <= div_cnt + 1'b1;
                end
                default:
                    state <= TX_IDLE;
            endcase
        end
    end

    // frame data leaves msb first
    always_ff @(posedge ep50trig)
    begin
        if (state == TX_IDLE && sim_tick)
            shift_reg <= muscle_len;
        else if (state == TX_SHIFT && div_done && sck)
            shift_reg <= {shift_reg[FRAME_BITS-2:0], 1'b0};
    end

    // the peer would see stray edges outside a frame
    a_sck_quiet: assert property (@(posedge ep50trig) disable iff (reset_global)
        ssel |-> $stable(sck));

endmodule

`default_nettype wire

/* source/rate_receiver.sv */
`default_nettype none

module rate_receiver
    import spi_pkg::*;
(
    input  wire logic ep50trig,
    input  wire logic reset_global,
    input  wire logic reset_sim,
    input  wire logic sck,
    input  wire logic mosi,
    input  wire logic ssel,
    input  wire logic spindle_tick,
    input  wire logic sim_tick,
    output frame_t    rawfr_ia
);

    // two-flop synchronizers
    logic [1:0] sck_sync;
    logic [1:0] ssel_sync;
    logic [1:0] mosi_sync;
    logic       sck_prev;
    logic       sck_rise;
    logic       frame_active;

    frame_t     shift_reg;
    frame_t     shift_next;
    bit_cnt_t   bit_cnt;
    logic       last_bit;
    frame_t     rx_word;
    frame_t     rx_safe;

    ////////////////////////////////////////
    // pin synchronizers
    ////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            sck_sync  <= 2'b00;
            sck_prev  <= 1'b0;
            // ssel idles high
            ssel_sync <= 2'b11;
        end
        else
        begin
            sck_sync  <= {sck_sync[0], sck};
            sck_prev  <= sck_sync[1];
            ssel_sync <= {ssel_sync[0], ssel};
        end
    end

    always_ff @(posedge ep50trig)
        mosi_sync <= {mosi_sync[0], mosi};

    assign sck_rise     = sck_sync[1] && !sck_prev;
    assign frame_active = !ssel_sync[1];

    ////////////////////////////////////////
    // bit shifter
    ////////////////////////////////////////

    assign shift_next = {shift_reg[FRAME_BITS-2:0], mosi_sync[1]};
    assign last_bit   = (bit_cnt == bit_cnt_t'(FRAME_BITS - 1));

    always_ff @(posedge ep50trig)
    begin
        if (frame_active && sck_rise)
            shift_reg <= shift_next;
    end

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            bit_cnt <= '0;
            rx_word <= '0;
        end
        // ssel high drops a partial frame
        else if (!frame_active)
            bit_cnt <= '0;
        else if (sck_rise)
        begin
            if (last_bit)
            begin
                bit_cnt <= '0;
                rx_word <= shift_next;
            end
            else
                bit_cnt <= bit_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////
    // two-stage hold
    ////////////////////////////////////////

    always_ff @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            rx_safe  <= '0;
            rawfr_ia <= '0;
        end
        else if (reset_sim)
        begin
            rx_safe  <= '0;
            rawfr_ia <= '0;
        end
        else
        begin
            // mid-period grab of the last whole word
            if (spindle_tick)
                rx_safe <= rx_word;
            // published at the period boundary
            if (sim_tick)
                rawfr_ia <= rx_safe;
        end
    end

    // a runaway count would mean a lost frame boundary
    a_bit_cnt_bound: assert property (@(posedge ep50trig) disable iff (reset_global)
        bit_cnt <= bit_cnt_t'(FRAME_BITS));

endmodule

`default_nettype wire

/* source/limb_link_top.sv */
`default_nettype none

module limb_link_top
    import host_pkg::*;
    import spi_pkg::*;
(
    input  wire logic       ep50trig,
    input  wire logic       reset_global,
    input  wire logic       reset_sim,
    input  wire trig_vec_t  trig,
    input  wire host_word_t rate_word,
    input  wire logic       pipe_write,
    input  wire host_word_t pipe_data,
    // from the second board
    input  wire logic       spi_in_sck,
    input  wire logic       spi_in_mosi,
    input  wire logic       spi_in_ssel,
    // to the second board
    output logic            spi_out_sck,
    output logic            spi_out_mosi,
    output logic            spi_out_ssel,
    output frame_t          muscle_len,
    output logic            lce_valid,
    output frame_t          rawfr_ia
);

    ////////////////////////////////////////
    // timing ticks
    ////////////////////////////////////////

    logic sim_tick;
    logic spindle_tick;

    sim_clock_gen clock_gen_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .trig         (trig),
        .rate_word    (rate_word),
        .sim_tick     (sim_tick),
        .spindle_tick (spindle_tick)
    );

    ////////////////////////////////////////
    // length path out
    ////////////////////////////////////////

    length_waveform waveform_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reset_sim    (reset_sim),
        .pipe_write   (pipe_write),
        .pipe_data    (pipe_data),
        .sim_tick     (sim_tick),
        .muscle_len   (muscle_len),
        .lce_valid    (lce_valid)
    );

    // frame carries the length shown at the previous tick
    spi_frame_tx spi_tx_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .sim_tick     (sim_tick),
        .muscle_len   (muscle_len),
        .sck          (spi_out_sck),
        .mosi         (spi_out_mosi),
        .ssel         (spi_out_ssel)
    );

    ////////////////////////////////////////
    // Ia rate path back
    ////////////////////////////////////////

    rate_receiver rate_rx_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reset_sim    (reset_sim),
        .sck          (spi_in_sck),
        .mosi         (spi_in_mosi),
        .ssel         (spi_in_ssel),
        .spindle_tick (spindle_tick),
        .sim_tick     (sim_tick),
        .rawfr_ia     (rawfr_ia)
    );

endmodule

`default_nettype wire

/* bench/tb_spi_peer.sv */
`default_nettype none

module tb_spi_peer
    import spi_pkg::*;
(
    input  wire logic     ep50trig,
    input  wire logic     reset_global,
    // frames coming from the DUT
    input  wire logic     listen_sck,
    input  wire logic     listen_mosi,
    input  wire logic     listen_ssel,
    // frames going back to the DUT
    output logic          talk_sck,
    output logic          talk_mosi,
    output logic          talk_ssel,
    input  wire logic     send_start,
    input  wire frame_t   send_word,
    input  wire bit_cnt_t send_bits,
    output logic          send_busy,
    output logic [15:0]   frames_seen,
    output frame_t        last_frame
);

    // half period well above the DUT synchronizer latency
    localparam int PEER_HALF = 8;

    logic        sck_seen;
    frame_t      rx_shift;
    bit_cnt_t    rx_bits;

    // idle levels hold before the first reset edge
    logic        drv_sck = 1'b0;
    logic        drv_mosi = 1'b0;
    logic        drv_ssel = 1'b1;
    logic        busy = 1'b0;
    frame_t      tx_shift;
    bit_cnt_t    tx_left;
    int unsigned tx_div;

    assign talk_sck  = drv_sck;
    assign talk_mosi = drv_mosi;
    assign talk_ssel = drv_ssel;
    assign send_busy = busy;

    ////////////////////////////////////////
    // frame decoder
    ////////////////////////////////////////

    always @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            sck_seen    <= 1'b0;
            rx_bits     <= '0;
            frames_seen <= '0;
            last_frame  <= '0;
        end
        else
        begin
            sck_seen <= listen_sck;
            // partial frames are thrown away
            if (listen_ssel)
                rx_bits <= '0;
            else if (listen_sck && !sck_seen)
            begin
                // msb arrives first
                rx_shift <= {rx_shift[FRAME_BITS-2:0], listen_mosi};
                if (rx_bits == bit_cnt_t'(FRAME_BITS - 1))
                begin
                    rx_bits     <= '0;
                    last_frame  <= {rx_shift[FRAME_BITS-2:0], listen_mosi};
                    frames_seen <= frames_seen + 1'b1;
                end
                else
                    rx_bits <= rx_bits + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // rate frame driver
    ////////////////////////////////////////

    always @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            drv_sck  <= 1'b0;
            drv_mosi <= 1'b0;
            drv_ssel <= 1'b1;
            busy     <= 1'b0;
            tx_div   <= 0;
        end
        else if (!busy)
        begin
            if (send_start)
            begin
                busy     <= 1'b1;
                drv_ssel <= 1'b0;
                drv_mosi <= send_word[FRAME_BITS-1];
                tx_shift <= send_word;
                tx_left  <= send_bits;
                tx_div   <= 0;
            end
        end
        else if (tx_div != PEER_HALF - 1)
            tx_div <= tx_div + 1;
        else
        begin
            tx_div <= 0;
            // a short bit count ends the frame early
            if (tx_left == '0)
            begin
                drv_ssel <= 1'b1;
                busy     <= 1'b0;
            end
            else if (!drv_sck)
                drv_sck <= 1'b1;
            else
            begin
                // next bit goes out on the falling edge
                drv_sck  <= 1'b0;
                tx_left  <= tx_left - 1'b1;
                tx_shift <= {tx_shift[FRAME_BITS-2:0], 1'b0};
                drv_mosi <= tx_shift[FRAME_BITS-2];
            end
        end
    end

endmodule

`default_nettype wire

/* bench/tb_limb_link.sv */
`default_nettype none

module tb_limb_link
    import host_pkg::*;
    import spi_pkg::*;
();

    // rate under test and its full tick period
    localparam host_word_t  RATE_TEST   = 16'd600;
    localparam int unsigned PERIOD_TEST = 2 * (RATE_TEST + 1);
    localparam int          FRAME_WAIT  = 2500;
    localparam int          PEER_WAIT   = 1000;

    logic        ep50trig = 1'b0;
    logic        reset_global;
    logic        reset_sim;
    trig_vec_t   trig;
    host_word_t  rate_word;
    logic        pipe_write;
    host_word_t  pipe_data;
    logic        spi_in_sck;
    logic        spi_in_mosi;
    logic        spi_in_ssel;
    logic        spi_out_sck;
    logic        spi_out_mosi;
    logic        spi_out_ssel;
    frame_t      muscle_len;
    logic        lce_valid;
    frame_t      rawfr_ia;

    // peer control and decoded frames
    logic        peer_start;
    frame_t      peer_word;
    bit_cnt_t    peer_bits;
    logic        peer_busy;
    logic [15:0] frames_seen;
    frame_t      last_frame;

    // bookkeeping
    int          errors = 0;
    int          errors_at_start;
    int          tests_run = 0;
    int          tests_failed = 0;
    string       test_name = "startup";
    int unsigned cycle_cnt = 0;
    int unsigned frames_checked;
    logic [31:0] rng_state = 32'h4235db34;
    int unsigned t_prev;
    int unsigned base;
    int          k;
    frame_t      word_a;
    frame_t      word_b;
    frame_t      elems [4];
    frame_t      fresh [2];

    always #50 ep50trig = !ep50trig;

    always @(posedge ep50trig)
        cycle_cnt <= cycle_cnt + 1;

    limb_link_top dut_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .reset_sim    (reset_sim),
        .trig         (trig),
        .rate_word    (rate_word),
        .pipe_write   (pipe_write),
        .pipe_data    (pipe_data),
        .spi_in_sck   (spi_in_sck),
        .spi_in_mosi  (spi_in_mosi),
        .spi_in_ssel  (spi_in_ssel),
        .spi_out_sck  (spi_out_sck),
        .spi_out_mosi (spi_out_mosi),
        .spi_out_ssel (spi_out_ssel),
        .muscle_len   (muscle_len),
        .lce_valid    (lce_valid),
        .rawfr_ia     (rawfr_ia)
    );

    // second board stand-in
    tb_spi_peer peer_i (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .listen_sck   (spi_out_sck),
        .listen_mosi  (spi_out_mosi),
        .listen_ssel  (spi_out_ssel),
        .talk_sck     (spi_in_sck),
        .talk_mosi    (spi_in_mosi),
        .talk_ssel    (spi_in_ssel),
        .send_start   (peer_start),
        .send_word    (peer_word),
        .send_bits    (peer_bits),
        .send_busy    (peer_busy),
        .frames_seen  (frames_seen),
        .last_frame   (last_frame)
    );

    ////////////////////////////////////////
    // reporting and helpers
    ////////////////////////////////////////

    task automatic count_failure(input string msg);
        $display("ERROR in %s: %s", test_name, msg);
        errors++;
    endtask

    task automatic print_mismatch(input logic [31:0] expected, input logic [31:0] actual);
        $display("MISMATCH %s expected %h actual %h", test_name, expected, actual);
        errors++;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout in %s while waiting for %s", test_name, what);
        $display("Test failures found");
        $finish;
    endtask

    task automatic start_test(input string name);
        test_name       = name;
        errors_at_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors != errors_at_start)
        begin
            tests_failed++;
            $display("test %s: FAIL with %0d errors", test_name, errors - errors_at_start);
        end
        else
            $display("test %s: PASS", test_name);
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_random(output frame_t w);
        rng_state = xorshift32(rng_state);
        w         = rng_state;
    endtask

    // low half first, then high half
    task automatic feed_pair(input frame_t w);
        @(posedge ep50trig);
        pipe_write <= 1'b1;
        pipe_data  <= w[15:0];
        @(posedge ep50trig);
        pipe_data  <= w[31:16];
        @(posedge ep50trig);
        pipe_write <= 1'b0;
    endtask

    task automatic peer_send(input frame_t w, input bit_cnt_t bits);
        @(posedge ep50trig);
        peer_start <= 1'b1;
        peer_word  <= w;
        peer_bits  <= bits;
        @(posedge ep50trig);
        peer_start <= 1'b0;
    endtask

    // returns just after ssel falls, one cycle after the tick
    task automatic wait_frame_start();
        logic prev;
        int   n;
        @(negedge ep50trig);
        prev = spi_out_ssel;
        for (n = 0; n < FRAME_WAIT; n++)
        begin
            @(negedge ep50trig);
            if (prev && !spi_out_ssel)
                return;
            prev = spi_out_ssel;
        end
        stop_on_timeout("an spi_out frame start");
    endtask

    task automatic wait_frame_decoded(input logic [15:0] seen_before);
        int n;
        for (n = 0; n < FRAME_WAIT; n++)
        begin
            @(negedge ep50trig);
            if (frames_seen != seen_before)
                return;
        end
        stop_on_timeout("the peer to decode a frame");
    endtask

    task automatic wait_peer_idle();
        int n;
        for (n = 0; n < PEER_WAIT; n++)
        begin
            @(negedge ep50trig);
            if (!peer_busy)
                return;
        end
        stop_on_timeout("the peer to finish its frame");
    endtask

    task automatic wait_checked_frames(input int unsigned target);
        int n;
        for (n = 0; n < 2 * FRAME_WAIT; n++)
        begin
            @(negedge ep50trig);
            if (frames_checked >= target)
                return;
        end
        stop_on_timeout("frames to pass the format monitor");
    endtask

    // each tick shows the new length while the frame carries the old one
    task automatic check_frame_step(input frame_t exp_len, input frame_t exp_frame);
        logic [15:0] seen_before;
        wait_frame_start();
        a_len_shown: assert (muscle_len === exp_len)
            else print_mismatch(exp_len, muscle_len);
        seen_before = frames_seen;
        wait_frame_decoded(seen_before);
        a_frame_word: assert (last_frame === exp_frame)
            else print_mismatch(exp_frame, last_frame);
    endtask

    ////////////////////////////////////////
    // spi_out format monitor
    ////////////////////////////////////////

    logic        ssel_q;
    logic        sck_q;
    int unsigned since_edge;
    int unsigned sck_rises;

    always @(posedge ep50trig or posedge reset_global)
    begin
        if (reset_global)
        begin
            ssel_q         <= 1'b1;
            sck_q          <= 1'b0;
            since_edge     <= 0;
            sck_rises      <= 0;
            frames_checked <= 0;
        end
        else
        begin
            ssel_q     <= spi_out_ssel;
            sck_q      <= spi_out_sck;
            since_edge <= since_edge + 1;
            if (ssel_q && !spi_out_ssel)
            begin
                since_edge <= 1;
                sck_rises  <= 0;
            end
            else if (!spi_out_ssel && (sck_q != spi_out_sck))
            begin
                // every sck change sits one half period after the last event
                a_half_period: assert (since_edge == SPI_CLK_DIV)
                    else print_mismatch(SPI_CLK_DIV, since_edge);
                since_edge <= 1;
                if (spi_out_sck)
                    sck_rises <= sck_rises + 1;
            end
            else if (!ssel_q && spi_out_ssel)
            begin
                a_ssel_gap: assert (since_edge == SPI_CLK_DIV)
                    else print_mismatch(SPI_CLK_DIV, since_edge);
                a_bit_total: assert (sck_rises == FRAME_BITS)
                    else print_mismatch(FRAME_BITS, sck_rises);
                frames_checked <= frames_checked + 1;
            end
        end
    end

    // frame starts one cycle after each tick
    a_frame_follows_tick: assert property (@(posedge ep50trig) disable iff (reset_global)
        dut_i.sim_tick |=> $fell(spi_out_ssel))
        else count_failure("spi_out_ssel did not fall one cycle after sim_tick");

    // only a buffer clear may drop lce_valid
    a_valid_sticky: assert property (@(posedge ep50trig) disable iff (reset_global)
        $fell(lce_valid) |-> $past(reset_sim))
        else count_failure("lce_valid fell without reset_sim");

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial
    begin
        reset_global = 1'b1;
        reset_sim    = 1'b0;
        trig         = '0;
        rate_word    = '0;
        pipe_write   = 1'b0;
        pipe_data    = '0;
        peer_start   = 1'b0;
        peer_word    = '0;
        peer_bits    = '0;
        repeat (3) @(posedge ep50trig);
        reset_global <= 1'b0;

        start_test("reset_state");
        @(negedge ep50trig);
        a_rst_ssel: assert (spi_out_ssel === 1'b1)
            else count_failure("spi_out_ssel is not high after reset");
        a_rst_sck: assert (spi_out_sck === 1'b0)
            else count_failure("spi_out_sck is not low after reset");
        a_rst_valid: assert (lce_valid === 1'b0)
            else count_failure("lce_valid is not low after reset");
        a_rst_len: assert (muscle_len === '0)
            else print_mismatch('0, muscle_len);
        a_rst_rate: assert (rawfr_ia === '0)
            else print_mismatch('0, rawfr_ia);
        end_test();

        start_test("rate_load");
        @(posedge ep50trig);
        trig[TRIG_RATE] <= 1'b1;
        rate_word       <= RATE_TEST;
        @(posedge ep50trig);
        trig            <= '0;
        wait_frame_start();
        t_prev = cycle_cnt;
        repeat (3)
        begin
            wait_frame_start();
            a_period: assert (cycle_cnt - t_prev == PERIOD_TEST)
                else print_mismatch(PERIOD_TEST, cycle_cnt - t_prev);
            t_prev = cycle_cnt;
        end
        end_test();

        start_test("frame_format");
        base = frames_checked;
        wait_checked_frames(base + 2);
        end_test();

        // feed right after a tick so no replay lands mid-feed
        start_test("replay_order");
        wait_frame_start();
        for (k = 0; k < 4; k++)
        begin
            next_random(word_a);
            elems[k] = word_a;
            feed_pair(word_a);
        end
        @(negedge ep50trig);
        a_valid_low: assert (lce_valid === 1'b0)
            else count_failure("lce_valid rose before any replay tick");
        check_frame_step(elems[0], '0);
        a_valid_high: assert (lce_valid === 1'b1)
            else count_failure("lce_valid did not rise on the first replay tick");
        for (k = 1; k <= 5; k++)
            check_frame_step(elems[k % 4], elems[(k - 1) % 4]);
        end_test();

        start_test("rate_capture");
        next_random(word_a);
        peer_send(word_a, bit_cnt_t'(FRAME_BITS));
        wait_peer_idle();
        wait_frame_start();
        wait_frame_start();
        a_rate_taken: assert (rawfr_ia === word_a)
            else print_mismatch(word_a, rawfr_ia);
        // cut short after 12 bits
        next_random(word_b);
        peer_send(word_b, bit_cnt_t'(12));
        wait_peer_idle();
        wait_frame_start();
        wait_frame_start();
        a_rate_kept: assert (rawfr_ia === word_a)
            else print_mismatch(word_a, rawfr_ia);
        // leftover bits of the cut frame must not shift into the next one
        next_random(word_b);
        peer_send(word_b, bit_cnt_t'(FRAME_BITS));
        wait_peer_idle();
        wait_frame_start();
        wait_frame_start();
        a_rate_after_cut: assert (rawfr_ia === word_b)
            else print_mismatch(word_b, rawfr_ia);
        end_test();

        start_test("buffer_clear");
        wait_frame_start();
        @(posedge ep50trig);
        reset_sim <= 1'b1;
        @(posedge ep50trig);
        reset_sim <= 1'b0;
        @(negedge ep50trig);
        a_clr_valid: assert (lce_valid === 1'b0)
            else count_failure("lce_valid stayed high after reset_sim");
        a_clr_len: assert (muscle_len === '0)
            else print_mismatch('0, muscle_len);
        for (k = 0; k < 2; k++)
        begin
            next_random(word_a);
            fresh[k] = word_a;
            feed_pair(word_a);
        end
        check_frame_step(fresh[0], '0);
        check_frame_step(fresh[1], fresh[0]);
        check_frame_step(fresh[0], fresh[1]);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
source/host_pkg.sv
source/spi_pkg.sv
source/sim_clock_gen.sv
source/length_waveform.sv
source/spi_frame_tx.sv
source/rate_receiver.sv
source/limb_link_top.sv
bench/tb_spi_peer.sv
bench/tb_limb_link.sv
